//--- Bender.yml
package:
  name: rv64i_core

sources:
  - logic/common_pkg.sv
  - logic/pipes_pkg.sv
  - logic/regfile_read_if.sv
  - logic/fetch.sv
  - logic/decode.sv
  - logic/execute.sv
  - logic/memory.sv
  - logic/regfile.sv
  - logic/core.sv
  - target: test
    files:
      - verification/core_assertions.sv
      - verification/core_tb.sv

//--- logic/common_pkg.sv
package common_pkg;

	localparam int xlen = 64;
	localparam int addr_width = 64;

	// first instruction after reset
	localparam logic [addr_width-1:0] reset_pc = 64'h0000_0000_8000_0000;

	typedef struct packed {
		logic                  valid;
		logic [addr_width-1:0] addr;
	} ibus_req_t;

	typedef struct packed {
		logic        ready;
		logic [31:0] data;
	} ibus_resp_t;

	typedef struct packed {
		logic                  valid;
		logic [addr_width-1:0] addr;
		logic                  write;
		logic [xlen-1:0]       wdata;
	} dbus_req_t;

	typedef struct packed {
		logic            ready;
		logic [xlen-1:0] rdata;
	} dbus_resp_t;

endpackage

//--- logic/core.sv
`timescale 1ns/1ps

module core
	import common_pkg::*;
	import pipes_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	output ibus_req_t  ireq,
	input  ibus_resp_t iresp,
	output dbus_req_t  dreq,
	input  dbus_resp_t dresp
);
	fetch_data_t     dataF;
	decode_data_t    dataD;
	execute_data_t   dataE;
	memory_data_t    dataM;
	logic            stopd;
	logic            stope;
	logic            stopm;
	logic            branch;
	logic [xlen-1:0] jump;
	tran_t           trane;
	tran_t           tranm;

	regfile_read_if rf_port();

	fetch fetch(
		.clk, .reset,
		.ireq, .iresp,
		.branch, .jump,
		.stop(stopd | stope | stopm),
		.dataF
	);
	decode decode(
		.clk, .reset,
		.dataF, .dataD,
		.rf(rf_port.reader),
		.trane, .tranm,
		.branch,
		.stope, .stopm, .stopd
	);
	execute execute(
		.clk, .reset,
		.dataD, .dataE,
		.stopm, .stope,
		.branch, .jump,
		.trane
	);
	memory memory(
		.clk, .reset,
		.dataE, .dataM,
		.dreq, .dresp,
		.stopm, .tranm
	);
	regfile regfile(
		.clk, .reset,
		.rf(rf_port.provider),
		.we(dataM.valid && dataM.ctl.regwrite),
		.rd(dataM.dst),
		.wdata(dataM.result)
	);
endmodule

//--- logic/decode.sv
`timescale 1ns/1ps

module decode
	import common_pkg::*;
	import pipes_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  fetch_data_t           dataF,
	output decode_data_t          dataD,
	regfile_read_if.reader        rf,
	input  tran_t                 trane,
	input  tran_t                 tranm,
	input  logic                  branch,
	input  logic                  stope,
	input  logic                  stopm,
	output logic                  stopd
);
	logic [31:0]     instr;
	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	op_t             op;
	control_t        ctl;
	logic            use1;
	logic            use2;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] rs1_val;
	logic [xlen-1:0] rs2_val;

	// newest producer wins
	function automatic logic [xlen-1:0] forward(input logic [4:0] r, input logic [xlen-1:0] q);
		if (r != 5'd0 && trane.dst == r)
			return trane.data;
		if (r != 5'd0 && tranm.dst == r)
			return tranm.data;
		return q;
	endfunction

	assign instr = dataF.instr;
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	always_comb begin
		op = NOP;
		case (opcode)
			7'b0010011: if (funct3 == 3'b000) op = ADDI;
			7'b0110011: begin
				case ({funct7, funct3})
					10'b0000000_000: op = ADD;
					10'b0100000_000: op = SUB;
					10'b0000000_111: op = AND;
					10'b0000000_110: op = OR;
					10'b0000000_100: op = XOR;
					default: op = NOP;
				endcase
			end
			7'b0110111: op = LUI;
			7'b0000011: if (funct3 == 3'b011) op = LD;
			7'b0100011: if (funct3 == 3'b011) op = SD;
			7'b1100011: begin
				if (funct3 == 3'b000)
					op = BEQ;
				else if (funct3 == 3'b001)
					op = BNE;
			end
			7'b1101111: op = JAL;
			default: op = NOP;
		endcase
	end

	assign ctl.op = op;
	assign ctl.regwrite = op inside {ADDI, ADD, SUB, AND, OR, XOR, LUI, LD, JAL};
	assign ctl.memread = (op == LD);
	assign ctl.memwrite = (op == SD);
	assign use1 = !(op inside {NOP, LUI, JAL});
	assign use2 = op inside {ADD, SUB, AND, OR, XOR, SD, BEQ, BNE};

	always_comb begin
		case (op)
			SD: imm = {{52{instr[31]}}, instr[31:25], instr[11:7]};
			BEQ, BNE: imm = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			LUI: imm = {{32{instr[31]}}, instr[31:12], 12'b0};
			JAL: imm = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			default: imm = {{52{instr[31]}}, instr[31:20]};
		endcase
	end

	// unused sources read x0 so they never match a forward
	assign rf.rs1 = use1 ? instr[19:15] : 5'd0;
	assign rf.rs2 = use2 ? instr[24:20] : 5'd0;

	// follows trane and tranm as well as the read port
	always_comb begin
		rs1_val = forward(rf.rs1, rf.q1);
		rs2_val = forward(rf.rs2, rf.q2);
	end

	// load result not ready until it leaves memory
	assign stopd = dataF.valid && trane.ismem && trane.dst != 5'd0
		&& (trane.dst == rf.rs1 || trane.dst == rf.rs2);

	always_ff @(posedge clk) begin
		if (reset) begin
			dataD.valid <= 1'b0;
		end else if (!(stope || stopm)) begin
			dataD.valid <= dataF.valid && !branch && !stopd;
			dataD.pc <= dataF.pc;
			dataD.ctl <= ctl;
			dataD.dst <= ctl.regwrite ? instr[11:7] : 5'd0;
			dataD.srca <= rs1_val;
			dataD.srcb <= (use2 && op != SD) ? rs2_val : imm;
			dataD.imm <= imm;
			dataD.sdata <= rs2_val;
		end
	end
endmodule

//--- logic/execute.sv
`timescale 1ns/1ps

module execute
	import common_pkg::*;
	import pipes_pkg::*;
(
	input  logic            clk,
	input  logic            reset,
	input  decode_data_t    dataD,
	output execute_data_t   dataE,
	input  logic            stopm,
	output logic            stope,
	output logic            branch,
	output logic [xlen-1:0] jump,
	output tran_t           trane
);
	logic [xlen-1:0] result;
	logic            taken;

	always_comb begin
		case (dataD.ctl.op)
			SUB: result = dataD.srca - dataD.srcb;
			AND: result = dataD.srca & dataD.srcb;
			OR: result = dataD.srca | dataD.srcb;
			XOR: result = dataD.srca ^ dataD.srcb;
			LUI: result = dataD.srcb;
			JAL: result = dataD.pc + 64'd4;
			// add, addi and load/store address
			default: result = dataD.srca + dataD.srcb;
		endcase
	end

	assign taken = dataD.valid && (dataD.ctl.op == JAL
		|| (dataD.ctl.op == BEQ && dataD.srca == dataD.srcb)
		|| (dataD.ctl.op == BNE && dataD.srca != dataD.srcb));

	// fire once, when the branch actually moves on
	assign branch = taken && !stopm;
	assign jump = dataD.pc + dataD.imm;
	assign stope = stopm;

	assign trane.dst = (dataD.valid && dataD.ctl.regwrite) ? dataD.dst : 5'd0;
	assign trane.data = result;
	assign trane.ismem = dataD.ctl.memread;

	always_ff @(posedge clk) begin
		if (reset) begin
			dataE.valid <= 1'b0;
		end else if (!stopm) begin
			dataE.valid <= dataD.valid;
			dataE.pc <= dataD.pc;
			dataE.ctl <= dataD.ctl;
			dataE.dst <= dataD.dst;
			dataE.result <= result;
			dataE.sdata <= dataD.sdata;
		end
	end
endmodule

//--- logic/fetch.sv
`timescale 1ns/1ps

module fetch
	import common_pkg::*;
	import pipes_pkg::*;
(
	input  logic            clk,
	input  logic            reset,
	output ibus_req_t       ireq,
	input  ibus_resp_t      iresp,
	input  logic            branch,
	input  logic [xlen-1:0] jump,
	input  logic            stop,
	output fetch_data_t     dataF
);
	logic [addr_width-1:0] pc;
	logic                  active;
	logic                  pending;
	logic                  fire;
	fetch_data_t           held;

	// a raised request stays up through a stall, a new one waits for it
	assign ireq.valid = active && !held.valid && (!stop || pending);
	assign ireq.addr = pc;
	assign fire = ireq.valid && iresp.ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_pc;
			active <= 1'b0;
			pending <= 1'b0;
			held.valid <= 1'b0;
			dataF.valid <= 1'b0;
		end else begin
			active <= 1'b1;
			pending <= ireq.valid && !iresp.ready && !branch;
			if (branch) begin
				// redirect drops whatever arrives this cycle
				pc <= jump;
				held.valid <= 1'b0;
				dataF.valid <= 1'b0;
			end else begin
				if (fire)
					pc <= pc + 64'd4;
				if (!stop) begin
					if (held.valid)
						dataF <= held;
					else
						dataF <= '{fire, pc, iresp.data};
					held.valid <= 1'b0;
				end else if (fire) begin
					// landed during a stall, park it
					held <= '{1'b1, pc, iresp.data};
				end
			end
		end
	end
endmodule

//--- logic/memory.sv
`timescale 1ns/1ps

module memory
	import common_pkg::*;
	import pipes_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  execute_data_t dataE,
	output memory_data_t  dataM,
	output dbus_req_t     dreq,
	input  dbus_resp_t    dresp,
	output logic          stopm,
	output tran_t         tranm
);
	logic [xlen-1:0] wb_data;

	// dataE is frozen while waiting, so the request stays stable
	assign dreq.valid = dataE.valid && (dataE.ctl.memread || dataE.ctl.memwrite);
	assign dreq.addr = dataE.result;
	assign dreq.write = dataE.ctl.memwrite;
	assign dreq.wdata = dataE.sdata;
	assign stopm = dreq.valid && !dresp.ready;

	assign wb_data = dataE.ctl.memread ? dresp.rdata : dataE.result;

	// value headed into dataM, visible to decode one cycle early
	assign tranm.dst = (dataE.valid && dataE.ctl.regwrite && !stopm) ? dataE.dst : 5'd0;
	assign tranm.data = wb_data;
	assign tranm.ismem = dataE.ctl.memread;

	always_ff @(posedge clk) begin
		if (reset) begin
			dataM.valid <= 1'b0;
		end else begin
			// bubble into writeback while the bus waits
			dataM.valid <= dataE.valid && !stopm;
			dataM.pc <= dataE.pc;
			dataM.ctl <= dataE.ctl;
			dataM.dst <= dataE.dst;
			dataM.result <= wb_data;
		end
	end
endmodule

//--- logic/pipes_pkg.sv
package pipes_pkg;
	import common_pkg::*;

	typedef enum logic [3:0] {
		NOP, ADDI, ADD, SUB, AND, OR, XOR, LUI, LD, SD, BEQ, BNE, JAL
	} op_t;

	typedef struct packed {
		op_t  op;
		logic regwrite;
		logic memread;
		logic memwrite;
	} control_t;

	typedef struct packed {
		logic                  valid;
		logic [addr_width-1:0] pc;
		logic [31:0]           instr;
	} fetch_data_t;

	// srcb already holds the immediate for non register-register ops
	typedef struct packed {
		logic                  valid;
		logic [addr_width-1:0] pc;
		control_t              ctl;
		logic [4:0]            dst;
		logic [xlen-1:0]       srca;
		logic [xlen-1:0]       srcb;
		logic [xlen-1:0]       imm;
		logic [xlen-1:0]       sdata;
	} decode_data_t;

	typedef struct packed {
		logic                  valid;
		logic [addr_width-1:0] pc;
		control_t              ctl;
		logic [4:0]            dst;
		logic [xlen-1:0]       result;
		logic [xlen-1:0]       sdata;
	} execute_data_t;

	typedef struct packed {
		logic                  valid;
		logic [addr_width-1:0] pc;
		control_t              ctl;
		logic [4:0]            dst;
		logic [xlen-1:0]       result;
	} memory_data_t;

	// dst of zero means nothing to forward
	typedef struct packed {
		logic [4:0]      dst;
		logic [xlen-1:0] data;
		logic            ismem;
	} tran_t;

endpackage

//--- logic/regfile.sv
`timescale 1ns/1ps

module regfile
	import common_pkg::*;
(
	input logic              clk,
	input logic              reset,
	regfile_read_if.provider rf,
	input logic              we,
	input logic [4:0]        rd,
	input logic [xlen-1:0]   wdata
);
	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

	// same-cycle write shows up on the read port
	assign rf.q1 = (we && rd != 5'd0 && rd == rf.rs1) ? wdata : regs[rf.rs1];
	assign rf.q2 = (we && rd != 5'd0 && rd == rf.rs2) ? wdata : regs[rf.rs2];
endmodule

//--- logic/regfile_read_if.sv
`timescale 1ns/1ps

interface regfile_read_if
	import common_pkg::*;
();
	logic [4:0]      rs1;
	logic [4:0]      rs2;
	logic [xlen-1:0] q1;
	logic [xlen-1:0] q2;

	modport reader (output rs1, rs2, input q1, q2);
	modport provider (input rs1, rs2, output q1, q2);
endinterface

//--- verification/core_assertions.sv
`timescale 1ns/1ps

module core_assertions
	import common_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input ibus_req_t  ireq,
	input ibus_resp_t iresp,
	input dbus_req_t  dreq,
	input dbus_resp_t dresp,
	input logic       branch
);
	int fail_count = 0;

	// a redirect may drop or replace the fetch request
	ireq_hold: assert property (@(posedge clk) disable iff (reset)
		ireq.valid && !iresp.ready && !branch |=> ireq.valid && $stable(ireq.addr))
		else begin
			$error("instruction request dropped or changed before ready");
			fail_count++;
		end

	dreq_hold: assert property (@(posedge clk) disable iff (reset)
		dreq.valid && !dresp.ready |=> dreq.valid && $stable(dreq.addr)
			&& $stable(dreq.write) && $stable(dreq.wdata))
		else begin
			$error("data request dropped or changed before ready");
			fail_count++;
		end

	// first cycle out of reset
	idle_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> !ireq.valid && !dreq.valid)
		else begin
			$error("bus request raised in the first cycle after reset");
			fail_count++;
		end
endmodule

bind core core_assertions handshake_checks (
	.clk, .reset, .ireq, .iresp, .dreq, .dresp, .branch
);

//--- verification/core_tb.sv
`timescale 1ns/1ps

module core_clock (
	output logic clk
);
	initial clk = 1'b0;
	always #4 clk = ~clk;
endmodule

module core_tb
	import common_pkg::*;
();
	localparam int prog_words = 48;
	localparam int count_index = 48;
	localparam int pairs_index = 49;
	localparam logic [63:0] end_addr = 64'h7f8;
	localparam int timeout_cycles = 2000;

	logic       clk;
	logic       reset;
	ibus_req_t  ireq;
	ibus_resp_t iresp;
	dbus_req_t  dreq;
	dbus_resp_t dresp;

	logic [63:0] testdata [0:127];
	logic [63:0] dmem [logic [63:0]];
	integer      seed;
	int          mismatches;
	int          failures;
	int          stores_seen;
	int          store_count;
	logic        done;

	core_clock clock0 (.clk(clk));

	core dut0 (
		.clk, .reset,
		.ireq, .iresp,
		.dreq, .dresp
	);

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			mismatches++;
			$display("mismatch %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	// NOP outside the loaded program
	function automatic logic [31:0] fetch_word(input logic [63:0] addr);
		logic [63:0] index;
		index = (addr - reset_pc) >> 2;
		if (addr < reset_pc || index >= prog_words || $isunknown(testdata[index]))
			return 32'h0000_0013;
		return testdata[index][31:0];
	endfunction

	function automatic logic [63:0] read_data(input logic [63:0] addr);
		if (dmem.exists(addr))
			return dmem[addr];
		return addr ^ 64'hc3c3_5a5a_0f0f_a5a5;
	endfunction

	task automatic record_store(input logic [63:0] addr, input logic [63:0] data);
		int slot;
		slot = pairs_index + 2 * stores_seen;
		if (stores_seen < store_count) begin
			check_value("dreq.addr", addr, testdata[slot]);
			check_value("dreq.wdata", data, testdata[slot + 1]);
		end else begin
			failures++;
			$display("unexpected store to address %h after the last expected store", addr);
		end
		stores_seen++;
	endtask

	// bus models, ready is random on both buses
	always @(posedge clk) begin
		#1;
		iresp.ready = ($random(seed) & 3) != 0;
		iresp.data = fetch_word(ireq.addr);
		dresp.ready = ($random(seed) & 3) != 0;
		dresp.rdata = read_data(dreq.addr);
	end

	// handshakes are stable mid cycle
	always @(negedge clk) begin
		if (!reset && dreq.valid && dresp.ready && dreq.write) begin
			dmem[dreq.addr] = dreq.wdata;
			if (dreq.addr == end_addr)
				done = 1'b1;
			else if (!done)
				record_store(dreq.addr, dreq.wdata);
		end
	end

	initial begin
		int cycles;
		seed = 32'hd1f210c3;
		mismatches = 0;
		failures = 0;
		stores_seen = 0;
		done = 1'b0;
		reset = 1'b1;
		iresp = '0;
		dresp = '0;
		$readmemh("verification/core_testdata.hex", testdata);
		store_count = int'(testdata[count_index][31:0]);

		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		cycles = 0;
		while (!done && cycles < timeout_cycles) begin
			@(posedge clk);
			cycles++;
		end
		if (!done) begin
			failures++;
			$display("timeout: no end marker store within %0d cycles", timeout_cycles);
		end

		check_value("store count", 64'(stores_seen), 64'(store_count));
		failures += dut0.handshake_checks.fail_count;

		$display("%0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end
endmodule

//--- verification/core_testdata.hex
// @00: program words from reset_pc, one 32 bit instruction each
// @30: number of expected stores, then one address and data pair per store
@00
00500093 00708113 002081b3 10303023
40118233 003242b3 10503423 0032f333
001363b3 10703823 12345437 10803c23
11803503 00150593 12b03023 00209463
20103023 00410463 20203423 00c0066f
20303823 20403c23 12c03423 00208463
12603823 7e003c23 0000006f
@30
0000000000000007
0000000000000100 0000000000000011
0000000000000108 000000000000001d
0000000000000110 0000000000000015
0000000000000118 0000000012345000
0000000000000120 0000000012345001
0000000000000128 0000000080000050
0000000000000130 0000000000000011

//--- verilog.f
logic/common_pkg.sv
logic/pipes_pkg.sv
logic/regfile_read_if.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/memory.sv
logic/regfile.sv
logic/core.sv
verification/core_assertions.sv
verification/core_tb.sv
